//--- common/icache_pkg.sv
`default_nettype none

package icache_pkg;

    // fetch address fields
    typedef logic [22:0] tag_t;
    typedef logic [5:0]  index_t;
    typedef logic [2:0]  offset_t;

    typedef logic [31:0] word_t;
    // low half holds the word at offset bit 2 == 0
    typedef logic [63:0] line_t;
    typedef logic [63:0] mem_addr_t;

    typedef struct packed {
        tag_t    tag;
        index_t  index;
        offset_t offset;
    } fetch_req_t;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        MISS,
        REFILL
    } icache_state_e;

    typedef logic [1:0] csr_addr_t;

    // bit 0 enable, bit 1 flush command
    localparam csr_addr_t CSR_CTRL   = 2'd0;
    localparam csr_addr_t CSR_HITS   = 2'd1;
    localparam csr_addr_t CSR_MISSES = 2'd2;

endpackage

`default_nettype wire

//--- hw/fetch_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_subsys_top #(
    parameter int cnt_width = 32
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   valid,
    input  icache_pkg::fetch_req_t req,
    output logic                   addr_ok,
    output logic                   data_ok,
    output icache_pkg::word_t      rdata,
    output logic                   rd_req,
    output icache_pkg::mem_addr_t  rd_addr,
    input  icache_pkg::line_t      ret_data,
    input  logic                   csr_wr,
    input  icache_pkg::csr_addr_t  csr_addr,
    input  icache_pkg::word_t      csr_wdata,
    output icache_pkg::word_t      csr_rdata
);

    logic enable;
    logic flush;
    logic hit_pulse;
    logic miss_pulse;

    icache u_icache (
        .clk        (clk),
        .rst        (rst),
        .valid      (valid),
        .req        (req),
        .addr_ok    (addr_ok),
        .data_ok    (data_ok),
        .rdata      (rdata),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .ret_data   (ret_data),
        .enable     (enable),
        .flush      (flush),
        .hit_pulse  (hit_pulse),
        .miss_pulse (miss_pulse)
    );

    icache_csr #(
        .cnt_width (cnt_width)
    ) u_csr (
        .clk        (clk),
        .rst        (rst),
        .csr_wr     (csr_wr),
        .csr_addr   (csr_addr),
        .csr_wdata  (csr_wdata),
        .csr_rdata  (csr_rdata),
        .enable     (enable),
        .flush      (flush),
        .hit_pulse  (hit_pulse),
        .miss_pulse (miss_pulse)
    );

endmodule

`default_nettype wire

//--- hw/icache_csr.sv
`timescale 1ns/1ps
`default_nettype none

module icache_csr #(
    parameter int cnt_width = 32
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  csr_wr,
    input  icache_pkg::csr_addr_t csr_addr,
    input  icache_pkg::word_t     csr_wdata,
    output icache_pkg::word_t     csr_rdata,
    output logic                  enable,
    output logic                  flush,
    input  logic                  hit_pulse,
    input  logic                  miss_pulse
);
    import icache_pkg::*;

    logic [cnt_width-1:0] hit_cnt;
    logic [cnt_width-1:0] miss_cnt;
    logic                 ctrl_wr;

    // counters stick at all ones
    function automatic logic [cnt_width-1:0] sat_inc(input logic [cnt_width-1:0] cnt);
        return (&cnt) ? cnt : cnt + 1'b1;
    endfunction

    assign ctrl_wr = csr_wr && (csr_addr == CSR_CTRL);

    always_ff @(posedge clk) begin
        if (rst) begin
            enable   <= 1'b1;
            flush    <= 1'b0;
            hit_cnt  <= '0;
            miss_cnt <= '0;
        end else begin
            flush <= ctrl_wr && csr_wdata[1];
            if (ctrl_wr) begin
                enable <= csr_wdata[0];
            end
            if (hit_pulse) begin
                hit_cnt <= sat_inc(hit_cnt);
            end
            if (miss_pulse) begin
                miss_cnt <= sat_inc(miss_cnt);
            end
        end
    end

    // flush bit is a command and reads back as zero
    always_comb begin
        case (csr_addr)
            CSR_CTRL:   csr_rdata = {31'b0, enable};
            CSR_HITS:   csr_rdata = word_t'(hit_cnt);
            CSR_MISSES: csr_rdata = word_t'(miss_cnt);
            default:    csr_rdata = '0;
        endcase
    end

    // one lookup gives exactly one outcome
    assert property (@(posedge clk) disable iff (rst) !(hit_pulse && miss_pulse))
        else $error("csr: hit and miss reported together");

endmodule

`default_nettype wire

//--- icache/icache.sv
`timescale 1ns/1ps
`default_nettype none

module icache (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   valid,
    input  icache_pkg::fetch_req_t req,
    output logic                   addr_ok,
    output logic                   data_ok,
    output icache_pkg::word_t      rdata,
    output logic                   rd_req,
    output icache_pkg::mem_addr_t  rd_addr,
    input  icache_pkg::line_t      ret_data,
    input  logic                   enable,
    input  logic                   flush,
    output logic                   hit_pulse,
    output logic                   miss_pulse
);
    import icache_pkg::*;

    icache_state_e state;
    icache_state_e next_state;
    fetch_req_t    req_q;
    logic          flush_pending;
    logic          invalidate;
    logic          accept;
    logic          repl_way;
    logic          fill_en;

    logic  way0_valid;
    logic  way1_valid;
    tag_t  way0_tag;
    tag_t  way1_tag;
    line_t way0_line;
    line_t way1_line;
    logic  way0_hit;
    logic  way1_hit;
    logic  cache_hit;
    line_t hit_line;

    function automatic word_t select_word(input line_t line, input logic hi);
        return hi ? line[63:32] : line[31:0];
    endfunction

    // arrays are read with the incoming index, data shows up in LOOKUP
    icache_tag_array u_tags (
        .clk        (clk),
        .rst        (rst),
        .rd_index   (req.index),
        .wr_en      (fill_en),
        .wr_way     (repl_way),
        .wr_index   (req_q.index),
        .wr_tag     (req_q.tag),
        .invalidate (invalidate),
        .way0_valid (way0_valid),
        .way1_valid (way1_valid),
        .way0_tag   (way0_tag),
        .way1_tag   (way1_tag)
    );

    icache_data_array u_data (
        .clk       (clk),
        .rd_index  (req.index),
        .wr_en     (fill_en),
        .wr_way    (repl_way),
        .wr_index  (req_q.index),
        .wr_line   (ret_data),
        .way0_line (way0_line),
        .way1_line (way1_line)
    );

    assign invalidate = (state == IDLE) && flush_pending;
    assign addr_ok    = (state == IDLE) && !flush_pending;
    assign accept     = valid && addr_ok;
    assign fill_en    = (state == REFILL) && enable;

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
    end

    // pending out of reset, so addr_ok stays low until the first IDLE pass
    always_ff @(posedge clk) begin
        if (rst) begin
            flush_pending <= 1'b1;
        end else if (flush) begin
            flush_pending <= 1'b1;
        end else if (invalidate) begin
            flush_pending <= 1'b0;
        end
    end

    // round robin, advances on each fill
    always_ff @(posedge clk) begin
        if (rst) begin
            repl_way <= 1'b0;
        end else if (fill_en) begin
            repl_way <= ~repl_way;
        end
    end

    assign way0_hit  = way0_valid && (way0_tag == req_q.tag);
    assign way1_hit  = way1_valid && (way1_tag == req_q.tag);
    assign cache_hit = enable && (way0_hit || way1_hit);
    assign hit_line  = way1_hit ? way1_line : way0_line;

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    next_state = LOOKUP;
                end
            end
            LOOKUP: begin
                next_state = cache_hit ? IDLE : MISS;
            end
            MISS: begin
                next_state = REFILL;
            end
            REFILL: begin
                next_state = IDLE;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    assign hit_pulse  = (state == LOOKUP) && cache_hit;
    assign miss_pulse = (state == LOOKUP) && !cache_hit;
    assign data_ok    = hit_pulse || (state == REFILL);
    // refill forwards the word straight from the memory return
    assign rdata      = (state == REFILL) ? select_word(ret_data, req_q.offset[2])
                                          : select_word(hit_line, req_q.offset[2]);

    assign rd_req  = (state == MISS);
    assign rd_addr = {32'b0, req_q.tag, req_q.index, 3'b000};

    // a refill answer always follows a memory read
    assert property (@(posedge clk) disable iff (rst)
        data_ok |-> (state == LOOKUP) || (state == REFILL && $past(rd_req)))
        else $error("icache: data_ok outside LOOKUP or REFILL");

    assert property (@(posedge clk) disable iff (rst)
        (state == LOOKUP) |-> !(way0_hit && way1_hit))
        else $error("icache: line present in both ways");

    assert property (@(posedge clk) disable iff (rst) rd_req |=> !rd_req)
        else $error("icache: rd_req held for two cycles");

endmodule

`default_nettype wire

//--- icache/icache_data_array.sv
`timescale 1ns/1ps
`default_nettype none

module icache_data_array (
    input  logic               clk,
    input  icache_pkg::index_t rd_index,
    input  logic               wr_en,
    input  logic               wr_way,
    input  icache_pkg::index_t wr_index,
    input  icache_pkg::line_t  wr_line,
    output icache_pkg::line_t  way0_line,
    output icache_pkg::line_t  way1_line
);
    import icache_pkg::*;

    localparam int num_sets = 2 ** $bits(index_t);

    line_t line_mem [2][num_sets];

    // one write port, both ways read every cycle
    always_ff @(posedge clk) begin
        if (wr_en) begin
            line_mem[wr_way][wr_index] <= wr_line;
        end
    end

    always_ff @(posedge clk) begin
        way0_line <= line_mem[0][rd_index];
        way1_line <= line_mem[1][rd_index];
    end

endmodule

`default_nettype wire

//--- icache/icache_tag_array.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tag_array (
    input  logic               clk,
    input  logic               rst,
    input  icache_pkg::index_t rd_index,
    input  logic               wr_en,
    input  logic               wr_way,
    input  icache_pkg::index_t wr_index,
    input  icache_pkg::tag_t   wr_tag,
    input  logic               invalidate,
    output logic               way0_valid,
    output logic               way1_valid,
    output icache_pkg::tag_t   way0_tag,
    output icache_pkg::tag_t   way1_tag
);
    import icache_pkg::*;

    localparam int num_sets = 2 ** $bits(index_t);

    logic [num_sets-1:0] valid_q [2];
    tag_t                tag_mem [2][num_sets];

    // valid bits live in flops so the whole array clears at once
    always_ff @(posedge clk) begin
        if (rst || invalidate) begin
            valid_q[0] <= '0;
            valid_q[1] <= '0;
        end else if (wr_en) begin
            valid_q[wr_way][wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            way0_valid <= 1'b0;
            way1_valid <= 1'b0;
        end else begin
            way0_valid <= valid_q[0][rd_index];
            way1_valid <= valid_q[1][rd_index];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_way][wr_index] <= wr_tag;
        end
        way0_tag <= tag_mem[0][rd_index];
        way1_tag <= tag_mem[1][rd_index];
    end

    // a flush is only applied while the cache sits in IDLE
    assert property (@(posedge clk) disable iff (rst) !(invalidate && wr_en))
        else $error("tag array: fill and invalidate in the same cycle");

endmodule

`default_nettype wire

//--- list.f
common/icache_pkg.sv
icache/icache_tag_array.sv
icache/icache_data_array.sv
icache/icache.sv
hw/icache_csr.sv
hw/fetch_subsys_top.sv
test/mem_model.sv
test/tb_fetch_subsys.sv

//--- test/mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module mem_model (
    input  logic                  clk,
    input  logic                  rd_req,
    input  icache_pkg::mem_addr_t rd_addr,
    output icache_pkg::line_t     ret_data
);
    import icache_pkg::*;

    word_t low_word;

    assign low_word = rd_addr[31:0] ^ 32'hc0de0000;

    initial begin
        ret_data = '0;
    end

    // line shows up the cycle after the strobe
    always @(posedge clk) begin
        if (rd_req) begin
            ret_data <= {low_word + 32'd4, low_word};
        end
    end

endmodule

`default_nettype wire

//--- test/tb_fetch_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_subsys;
    import icache_pkg::*;

    localparam int clk_period = 100;
    localparam int planned_requests = 2 + 6 + 3 + 6 + 200;

    logic       clk;
    logic       rst;
    logic       valid;
    fetch_req_t req;
    logic       addr_ok;
    logic       data_ok;
    word_t      rdata;
    logic       rd_req;
    mem_addr_t  rd_addr;
    line_t      ret_data;
    logic       csr_wr;
    csr_addr_t  csr_addr;
    word_t      csr_wdata;
    word_t      csr_rdata;

    // reference cache
    logic ref_valid [2][64];
    tag_t ref_tag [2][64];
    logic ref_rr;
    logic ref_enable;
    int   ref_hits;
    int   ref_misses;

    int          checks;
    int          errors;
    int          errors_at_start;
    int          tests_run;
    logic [31:0] lfsr;

    fetch_subsys_top #(
        .cnt_width (32)
    ) UUT (
        .clk       (clk),
        .rst       (rst),
        .valid     (valid),
        .req       (req),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .ret_data  (ret_data),
        .csr_wr    (csr_wr),
        .csr_addr  (csr_addr),
        .csr_wdata (csr_wdata),
        .csr_rdata (csr_rdata)
    );

    mem_model u_mem (
        .clk      (clk),
        .rd_req   (rd_req),
        .rd_addr  (rd_addr),
        .ret_data (ret_data)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(planned_requests * 100 * clk_period);
        $display("timeout: run still busy after %0d cycles", planned_requests * 100);
        $display("*** TEST FAILED ***");
        $finish;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // memory rule: low word is the line address xor c0de0000, high word is that plus 4
    function automatic word_t expected_word(input tag_t tag, input index_t idx,
                                            input offset_t off);
        word_t lo;
        lo = {tag, idx, 3'b000} ^ 32'hc0de0000;
        return off[2] ? lo + 32'd4 : lo;
    endfunction

    task automatic model_access(input tag_t tag, input index_t idx, output logic hit);
        hit = ref_enable && ((ref_valid[0][idx] && ref_tag[0][idx] == tag) ||
                             (ref_valid[1][idx] && ref_tag[1][idx] == tag));
        if (hit) begin
            ref_hits++;
        end else begin
            ref_misses++;
            if (ref_enable) begin
                ref_valid[ref_rr][idx] = 1'b1;
                ref_tag[ref_rr][idx] = tag;
                ref_rr = ~ref_rr;
            end
        end
    endtask

    task automatic model_flush();
        for (int i = 0; i < 64; i++) begin
            ref_valid[0][i] = 1'b0;
            ref_valid[1][i] = 1'b0;
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAIL t=%0t %s: got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic csr_write(input csr_addr_t a, input word_t d);
        csr_wr = 1'b1;
        csr_addr = a;
        csr_wdata = d;
        @(posedge clk);
        #1;
        csr_wr = 1'b0;
    endtask

    task automatic csr_expect(input csr_addr_t a, input word_t exp, input string name);
        csr_addr = a;
        #1;
        check_value(name, csr_rdata, exp);
        @(posedge clk);
        #1;
    endtask

    task automatic fetch(input tag_t tag, input index_t idx, input offset_t off);
        int        n;
        int        wait_cnt;
        int        data_cycle;
        int        rd_cycle;
        word_t     got_word;
        mem_addr_t seen_addr;
        logic      exp_hit;
        wait_cnt = 0;
        while (addr_ok !== 1'b1 && wait_cnt < 10) begin
            @(posedge clk);
            #1;
            wait_cnt++;
        end
        checks++;
        assert (addr_ok === 1'b1) else begin
            $display("addr_ok stayed low for %0d cycles at t=%0t", wait_cnt, $time);
            errors++;
            return;
        end
        model_access(tag, idx, exp_hit);
        valid = 1'b1;
        req = '{tag, idx, off};
        @(posedge clk);
        #1;
        valid = 1'b0;
        n = 1;
        data_cycle = 0;
        rd_cycle = 0;
        got_word = '0;
        seen_addr = '0;
        // cycle 1 is LOOKUP
        while (n <= 6) begin
            if (rd_req === 1'b1) begin
                rd_cycle = n;
                seen_addr = rd_addr;
            end
            if (data_ok === 1'b1) begin
                data_cycle = n;
                got_word = rdata;
                break;
            end
            @(posedge clk);
            #1;
            n++;
        end
        check_value("data_ok cycle", data_cycle, exp_hit ? 1 : 3);
        check_value("rdata", got_word, expected_word(tag, idx, off));
        check_value("rd_req cycle", rd_cycle, exp_hit ? 0 : 2);
        if (!exp_hit) begin
            check_value("rd_addr", seen_addr, {32'b0, tag, idx, 3'b000});
        end
    endtask

    task automatic end_test(input string name);
        // counters catch the last lookup pulse on the next edge
        @(posedge clk);
        #1;
        csr_expect(CSR_HITS, ref_hits, "csr_rdata hits");
        csr_expect(CSR_MISSES, ref_misses, "csr_rdata misses");
        tests_run++;
        $display("test %0d %s: %0d errors", tests_run, name, errors - errors_at_start);
        errors_at_start = errors;
    endtask

    initial begin
        logic [31:0] r;
        rst = 1'b1;
        valid = 1'b0;
        req = '0;
        csr_wr = 1'b0;
        csr_addr = CSR_CTRL;
        csr_wdata = '0;
        lfsr = 32'h1accebe6;
        checks = 0;
        errors = 0;
        errors_at_start = 0;
        tests_run = 0;
        ref_rr = 1'b0;
        ref_enable = 1'b1;
        ref_hits = 0;
        ref_misses = 0;
        model_flush();

        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            #1;
            check_value("addr_ok", addr_ok, 0);
            check_value("data_ok", data_ok, 0);
            check_value("rd_req", rd_req, 0);
        end
        rst = 1'b0;
        csr_expect(CSR_CTRL, 32'd1, "csr_rdata ctrl");
        end_test("reset");

        fetch(23'h12345, 6'h0a, 3'h4);
        fetch(23'h12345, 6'h0a, 3'h4);
        end_test("cold miss then hit");

        // three tags share one set
        fetch(23'h00a01, 6'h15, 3'h0);
        fetch(23'h00b02, 6'h15, 3'h4);
        fetch(23'h00c03, 6'h15, 3'h0);
        fetch(23'h00b02, 6'h15, 3'h0);
        fetch(23'h00a01, 6'h15, 3'h4);
        fetch(23'h00c03, 6'h15, 3'h4);
        end_test("conflict");

        fetch(23'h12345, 6'h0a, 3'h0);
        csr_write(CSR_CTRL, 32'd3);
        @(posedge clk);
        #1;
        check_value("addr_ok", addr_ok, 0);
        model_flush();
        fetch(23'h12345, 6'h0a, 3'h0);
        fetch(23'h12345, 6'h0a, 3'h4);
        end_test("flush");

        csr_write(CSR_CTRL, 32'd0);
        ref_enable = 1'b0;
        csr_expect(CSR_CTRL, 32'd0, "csr_rdata ctrl");
        for (int k = 0; k < 2; k++) begin
            fetch(23'h3f0e1, 6'h21, 3'h0);
            fetch(23'h3f0e2, 6'h22, 3'h4);
            fetch(23'h3f0e3, 6'h23, 3'h0);
            if (k == 0) begin
                csr_write(CSR_CTRL, 32'd1);
                ref_enable = 1'b1;
            end
        end
        end_test("disabled cache");

        // few indices and tags so hits and evictions mix
        for (int k = 0; k < 200; k++) begin
            take_bits(8, r);
            fetch({20'h2b3c1, r[7:5]}, {4'b1100, r[4:3]}, r[2:0]);
        end
        end_test("random sequence");

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
